// File: list.f
rtl/tri_pkg.sv
rtl/tri_reg_decode.sv
rtl/tri_linear_counter.sv
rtl/tri_freq_timer.sv
rtl/tri_sequencer.sv
rtl/tri_channel.sv
tb/tri_channel_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tri_channel_tb
FILELIST = list.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tri_channel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tri_channel_tb;

	import tri_pkg::*;

	localparam int CHANGE_LIMIT = 200;	// cycles allowed per level change
	localparam int BUDGET_CYCLES = 20 + 40 * CHANGE_LIMIT + 3 * (4 * CHANGE_LIMIT + 4)
		+ 21 * (CHANGE_LIMIT + 2) + 4 * 41 + 4 * CHANGE_LIMIT + 6 * 41 + 20;
	localparam longint WATCHDOG_NS = 2 * 100 * longint'(BUDGET_CYCLES);

	logic       phi1;
	logic       rst_n;
	logic       wr;
	reg_sel_t   reg_sel;
	logic [7:0] data;
	logic       lfo_tick;
	logic       lock;
	logic       length_zero;
	tri_level_t tri_out;
	logic       length_halt;

	logic [31:0] lfsr;
	int          seq_idx;	// steps taken by the model sequencer
	int          value_errors;
	int          stall_errors;
	period_t     period;

	tri_channel uut (
		.phi1        (phi1),
		.rst_n       (rst_n),
		.wr          (wr),
		.reg_sel     (reg_sel),
		.data        (data),
		.lfo_tick    (lfo_tick),
		.lock        (lock),
		.length_zero (length_zero),
		.tri_out     (tri_out),
		.length_halt (length_halt)
	);

	initial begin
		phi1 = 1'b0;
		forever #50 phi1 = ~phi1;
	end

	// **********************************************************************
	// model and stimulus helpers
	// **********************************************************************

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// 15 down to 0, then 0 up to 15
	function automatic tri_level_t level_of(input int i);
		int k;
		k = i % 32;
		if (k < 16)
			return tri_level_t'(15 - k);
		return tri_level_t'(k - 16);
	endfunction

	task automatic rand_range(input int lo, input int hi, output int v);
		int bits;
		bits = 0;
		repeat (6) begin
			lfsr = lfsr_next(lfsr);
			bits = (bits << 1) | int'(lfsr[0]);	// one step per bit
		end
		v = lo + bits % (hi - lo + 1);
	endtask

	task automatic tick();
		@(posedge phi1);
		#10;
	endtask

	task automatic write_reg(input reg_sel_t sel, input logic [7:0] val);
		wr = 1'b1;
		reg_sel = sel;
		data = val;
		tick();
		wr = 1'b0;
	endtask

	task automatic pulse_lfo();
		lfo_tick = 1'b1;
		tick();
		lfo_tick = 1'b0;
	endtask

	task automatic check_level(input string name, input tri_level_t exp, input tri_level_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Fail %s: expected %0b, actual %0b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("Fail %s: expected %0d cycles, actual %0d cycles", name, exp, act);
			value_errors++;
		end
	endtask

	// waits for the next visible change where a repeated level costs two steps
	task automatic next_change(input string name, input bit timed);
		int         cycles;
		int         steps;
		tri_level_t cur;
		cur = level_of(seq_idx);
		cycles = 0;
		while (tri_out == cur && cycles < CHANGE_LIMIT) begin
			tick();
			cycles++;
		end
		if (tri_out == cur) begin
			$display("%s: level stayed at %0d for %0d cycles", name, cur, CHANGE_LIMIT);
			stall_errors++;
		end else begin
			steps = (level_of(seq_idx + 1) == cur) ? 2 : 1;
			seq_idx += steps;
			check_level(name, level_of(seq_idx), tri_out);
			if (timed)
				check_cycles(name, steps * (int'(period) + 1), cycles);
		end
	endtask

	task automatic hold_check(input string name, input int n);
		repeat (n) begin
			tick();
			check_level(name, level_of(seq_idx), tri_out);
		end
	endtask

	task automatic new_period();
		int v;
		rand_range(6, 40, v);
		period = period_t'(v);
		write_reg(REG_PERIOD_LO, period[7:0]);
		write_reg(REG_PERIOD_HI, {5'd0, period[10:8]});	// also sets the reload flag
	endtask

	// **********************************************************************
	// tests
	// **********************************************************************

	task automatic test_reset();
		check_level("reset", 4'd15, tri_out);
		check_bit("reset", 1'b0, length_halt);
	endtask

	task automatic test_control();
		write_reg(REG_LINEAR, 8'h85);
		check_bit("control set", 1'b1, length_halt);
		write_reg(2'd1, 8'h0a);
		check_bit("index 1", 1'b1, length_halt);
		check_level("index 1", level_of(seq_idx), tri_out);
		write_reg(REG_LINEAR, 8'h05);
		check_bit("control clear", 1'b0, length_halt);
	endtask

	task automatic test_sequence();
		int v;
		int start;
		int n;
		new_period();
		rand_range(3, 20, v);
		write_reg(REG_LINEAR, {1'b1, lin_count_t'(v)});
		pulse_lfo();
		start = seq_idx;
		n = 0;
		while (seq_idx < start + 33 && n < 40) begin
			next_change("sequence", n > 1);
			n++;
		end
	endtask

	task automatic test_rate();
		repeat (3) begin
			new_period();
			next_change("rate", 1'b0);	// old period still in the timer
			next_change("rate", 1'b0);
			next_change("rate", 1'b1);
			next_change("rate", 1'b1);
		end
	endtask

	task automatic test_expiry();
		int l;
		rand_range(3, 20, l);
		write_reg(REG_LINEAR, {1'b0, lin_count_t'(l)});
		write_reg(REG_PERIOD_HI, {5'd0, period[10:8]});
		for (int t = 1; t <= l + 1; t++) begin
			next_change("expiry", 1'b0);
			pulse_lfo();
		end
		hold_check("expiry freeze", 4 * (int'(period) + 1));
	endtask

	task automatic test_freeze();
		int l;
		rand_range(3, 20, l);
		write_reg(REG_LINEAR, {1'b1, lin_count_t'(l)});
		write_reg(REG_PERIOD_HI, {5'd0, period[10:8]});
		pulse_lfo();
		next_change("freeze", 1'b0);
		next_change("freeze", 1'b0);
		lock = 1'b1;
		hold_check("lock hold", 3 * (int'(period) + 1));
		lock = 1'b0;
		next_change("lock release", 1'b0);
		length_zero = 1'b1;
		hold_check("length zero hold", 3 * (int'(period) + 1));
		length_zero = 1'b0;
		next_change("length zero release", 1'b0);
	endtask

	initial begin
		rst_n = 1'b0;
		wr = 1'b0;
		reg_sel = '0;
		data = '0;
		lfo_tick = 1'b0;
		lock = 1'b0;
		length_zero = 1'b0;
		lfsr = 32'h78ed;
		seq_idx = 0;
		value_errors = 0;
		stall_errors = 0;
		period = '0;
		repeat (4) @(posedge phi1);
		#10;
		rst_n = 1'b1;
		test_reset();
		test_control();
		test_sequence();
		test_rate();
		test_expiry();
		test_freeze();
		$display("errors: %0d wrong values, %0d missing level changes", value_errors,
			stall_errors);
		if (value_errors + stall_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/tri_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tri_channel (
	input  wire                 phi1,
	input  wire                 rst_n,
	input  wire                 wr,
	input  tri_pkg::reg_sel_t   reg_sel,
	input  wire [7:0]           data,
	input  wire                 lfo_tick,
	input  wire                 lock,
	input  wire                 length_zero,
	output tri_pkg::tri_level_t tri_out,
	output logic                length_halt
);

	import tri_pkg::*;

	// **********************************************************************
	// internal wires
	// **********************************************************************

	tri_cfg_t cfg;
	logic     reload_req;
	logic     reload_clr;
	logic     lin_active;
	logic     step;

	assign length_halt = cfg.halt;	// to the length counter

	// **********************************************************************
	// stages
	// **********************************************************************

	tri_reg_decode u_decode (
		.phi1       (phi1),
		.rst_n      (rst_n),
		.wr         (wr),
		.reg_sel    (reg_sel),
		.data       (data),
		.reload_clr (reload_clr),
		.cfg        (cfg),
		.reload_req (reload_req)
	);

	tri_linear_counter u_lin_cnt (
		.phi1       (phi1),
		.rst_n      (rst_n),
		.lfo_tick   (lfo_tick),
		.halt       (cfg.halt),
		.lin_reload (cfg.lin_reload),
		.reload_req (reload_req),
		.reload_clr (reload_clr),
		.lin_active (lin_active)
	);

	tri_freq_timer u_freq (
		.phi1   (phi1),
		.rst_n  (rst_n),
		.period (cfg.period),
		.step   (step)
	);

	tri_sequencer u_seq (
		.phi1        (phi1),
		.rst_n       (rst_n),
		.step        (step),
		.lin_active  (lin_active),
		.lock        (lock),
		.length_zero (length_zero),
		.tri_out     (tri_out)
	);

endmodule

`default_nettype wire

// File: rtl/tri_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tri_sequencer (
	input  wire                 phi1,
	input  wire                 rst_n,
	input  wire                 step,
	input  wire                 lin_active,
	input  wire                 lock,
	input  wire                 length_zero,
	output tri_pkg::tri_level_t tri_out
);

	import tri_pkg::*;

	seq_phase_t phase;
	logic       advance;

	// gated step
	assign advance = step & lin_active & ~lock & ~length_zero;

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (advance) begin
			phase <= phase + 1'b1;	// wraps after 32 steps
		end
	end

	// first half falls 15..0, second half rises 0..15
	assign tri_out = phase[4] ? phase[3:0] : ~phase[3:0];

	a_lock_hold: assert property (
		@(posedge phi1) disable iff (!rst_n)
		lock |=> $stable(phase)
	);

endmodule

`default_nettype wire

// File: rtl/tri_freq_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tri_freq_timer (
	input  wire              phi1,
	input  wire              rst_n,
	input  tri_pkg::period_t period,
	output logic             step
);

	import tri_pkg::*;

	period_t cnt;
	logic    cnt_zero;

	assign cnt_zero = (cnt == '0);

	// **********************************************************************
	// free-running divider, reloads from the period at zero
	// **********************************************************************

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt_zero) begin
			cnt <= period;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// one step per period+1 cycles
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			step <= 1'b0;
		end else begin
			step <= cnt_zero;
		end
	end

	// back-to-back steps only with a zero period loaded
	a_step_single: assert property (
		@(posedge phi1) disable iff (!rst_n)
		(step && $past(period) != '0) |=> !step
	);

endmodule

`default_nettype wire

// File: rtl/tri_linear_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tri_linear_counter (
	input  wire                 phi1,
	input  wire                 rst_n,
	input  wire                 lfo_tick,
	input  wire                 halt,
	input  tri_pkg::lin_count_t lin_reload,
	input  wire                 reload_req,
	output logic                reload_clr,
	output logic                lin_active
);

	import tri_pkg::*;

	lin_count_t count;

	// **********************************************************************
	// quarter-frame counter
	// **********************************************************************

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (lfo_tick) begin
			if (reload_req) begin
				count <= lin_reload;
			end else if (count != '0) begin
				count <= count - 1'b1;	// stops at zero
			end
		end
	end

	// with halt set the flag stays and the count reloads on every tick
	assign reload_clr = lfo_tick & ~halt;

	assign lin_active = (count != '0);	// note still sounding

	// no wrap below zero
	a_no_wrap: assert property (
		@(posedge phi1) disable iff (!rst_n)
		(count == '0 && !(lfo_tick && reload_req)) |=> (count != 7'd127)
	);

endmodule

`default_nettype wire

// File: rtl/tri_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tri_reg_decode (
	input  wire               phi1,
	input  wire               rst_n,
	input  wire               wr,
	input  tri_pkg::reg_sel_t reg_sel,
	input  wire [7:0]         data,
	input  wire               reload_clr,
	output tri_pkg::tri_cfg_t cfg,
	output logic              reload_req
);

	import tri_pkg::*;

	logic wr_period_hi;

	assign wr_period_hi = wr && (reg_sel == REG_PERIOD_HI);

	// **********************************************************************
	// channel registers
	// **********************************************************************

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (wr) begin
			case (reg_sel)
				REG_LINEAR: begin
					cfg.halt       <= data[7];
					cfg.lin_reload <= data[6:0];
				end
				REG_PERIOD_LO: begin
					cfg.period[7:0] <= data;
				end
				REG_PERIOD_HI: begin
					cfg.period[10:8] <= data[2:0];	// only 3 bits used
				end
				default: begin
				end
			endcase
		end
	end

	// set has priority over clear on the reload flag
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_req <= 1'b0;
		end else if (wr_period_hi) begin
			reload_req <= 1'b1;
		end else if (reload_clr) begin
			reload_req <= 1'b0;
		end
	end

	// **********************************************************************
	// checks
	// **********************************************************************

	// index 1 belongs to no register of this channel
	a_idx1_ignored: assert property (
		@(posedge phi1) disable iff (!rst_n)
		(wr && reg_sel == 2'd1) |=> $stable(cfg)
	);

endmodule

`default_nettype wire

// File: rtl/tri_pkg.sv
`default_nettype none

package tri_pkg;

	// **********************************************************************
	// widths fixed by the register map
	// **********************************************************************

	typedef logic [6:0]  lin_count_t;	// linear counter and its reload value
	typedef logic [10:0] period_t;		// frequency timer period
	typedef logic [4:0]  seq_phase_t;	// 32-step sequencer phase
	typedef logic [3:0]  tri_level_t;	// output level
	typedef logic [1:0]  reg_sel_t;		// channel register index

	// **********************************************************************
	// register indices, index 1 has no function on this channel
	// **********************************************************************

	localparam reg_sel_t REG_LINEAR    = 2'd0;
	localparam reg_sel_t REG_PERIOD_LO = 2'd2;
	localparam reg_sel_t REG_PERIOD_HI = 2'd3;

	// channel configuration, 19 bits
	typedef struct packed {
		logic       halt;		// control bit, also halts the length counter
		lin_count_t lin_reload;
		period_t    period;
	} tri_cfg_t;

endpackage

`default_nettype wire
